/* list.f */
rtl/rv32i_pkg.sv
rtl/regfile.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/mem_arbiter.sv
rtl/core_top.sv
test/core_checker.sv
test/tb_top.sv

/* rtl/core_top.sv */
`timescale 1ns/100ps

module core_top import rv32i_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    output logic        o_mem_req_valid,
    output mem_req_t    o_mem_req,
    input  logic        i_mem_rvalid,
    input  logic [31:0] i_mem_rdata,
    output logic        o_retire_valid,
    output retire_t     o_retire
);

    if_id_t      if_id;
    id_ex_t      id_ex;
    logic        decode_ready;
    logic        ex_accept;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [4:0]  rs1_s;
    logic [4:0]  rs2_s;
    logic [31:0] rs1_v;
    logic [31:0] rs2_v;
    logic        fetch_req_valid;
    mem_req_t    fetch_req;
    logic        fetch_resp;
    logic        data_req_valid;
    mem_req_t    data_req;
    logic        data_resp;

    fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
        .clk(clk), .rst(rst),
        .i_decode_ready(decode_ready), .i_redirect(redirect), .i_redirect_pc(redirect_pc),
        .o_req_valid(fetch_req_valid), .o_req(fetch_req),
        .i_resp_valid(fetch_resp), .i_resp_data(i_mem_rdata), .o_if_id(if_id)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .i_if_id(if_id), .o_decode_ready(decode_ready),
        .i_ex_accept(ex_accept), .i_flush(redirect), .o_rs1_s(rs1_s), .o_rs2_s(rs2_s),
        .i_rs1_v(rs1_v), .i_rs2_v(rs2_v), .o_id_ex(id_ex)
    );

    // write port is fed straight from the retire record
    regfile u_regfile (
        .clk(clk), .rst(rst), .i_we(o_retire.reg_we), .i_rd_s(o_retire.rd),
        .i_rd_v(o_retire.rd_value), .i_rs1_s(rs1_s), .i_rs2_s(rs2_s),
        .o_rs1_v(rs1_v), .o_rs2_v(rs2_v)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .i_id_ex(id_ex), .o_accept(ex_accept),
        .o_redirect(redirect), .o_redirect_pc(redirect_pc),
        .o_req_valid(data_req_valid), .o_req(data_req),
        .i_resp_valid(data_resp), .i_resp_data(i_mem_rdata),
        .o_retire_valid(o_retire_valid), .o_retire(o_retire)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .rst(rst),
        .i_fetch_valid(fetch_req_valid), .i_fetch_req(fetch_req),
        .i_data_valid(data_req_valid), .i_data_req(data_req),
        .o_fetch_grant(), .o_data_grant(), // owners hold their request until answered
        .o_fetch_resp(fetch_resp), .o_data_resp(data_resp),
        .o_mem_req_valid(o_mem_req_valid), .o_mem_req(o_mem_req), .i_mem_rvalid(i_mem_rvalid)
    );

endmodule

/* rtl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import rv32i_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  if_id_t      i_if_id,
    output logic        o_decode_ready,
    input  logic        i_ex_accept,
    input  logic        i_flush,
    output logic [4:0]  o_rs1_s,
    output logic [4:0]  o_rs2_s,
    input  logic [31:0] i_rs1_v,
    input  logic [31:0] i_rs2_v,
    output id_ex_t      o_id_ex
);

    logic [31:0] inst;
    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] imm;
    ctrl_t       ctrl;
    id_ex_t      id_ex_d;
    id_ex_t      id_ex_q;

    assign inst    = i_if_id.inst;
    assign opcode  = opcode_e'(inst[6:0]);
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign o_rs1_s = inst[19:15]; // regfile answers in this same cycle
    assign o_rs2_s = inst[24:20];

    assign imm_i = {{21{inst[31]}}, inst[30:20]};
    assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};
    assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        ctrl = '0;
        imm  = imm_i;
        case (opcode)
            op_lui: begin
                imm         = imm_u;
                ctrl.wb_sel = wb_u_imm;
                ctrl.reg_we = 1'b1;
            end
            op_auipc: begin
                imm               = imm_u;
                ctrl.alu_src1_pc  = 1'b1;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.reg_we       = 1'b1;
            end
            op_imm, op_reg: begin
                ctrl.reg_we       = 1'b1;
                ctrl.alu_src2_imm = (opcode == op_imm);
                ctrl.cmp_src_imm  = (opcode == op_imm);
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    ctrl.cmp_op = funct3[0] ? cmp_bltu : cmp_blt; // slt and sltu
                    ctrl.wb_sel = wb_cmp;
                end else if (opcode == op_imm) begin
                    // bit 30 is an immediate bit except on the shifts
                    ctrl.alu_op = alu_op_e'({(funct3 == 3'b101) & funct7[5], funct3});
                end else begin
                    ctrl.alu_op = alu_op_e'({funct7[5], funct3}); // sub and sra
                end
            end
            op_load: begin
                ctrl.alu_src2_imm = 1'b1;
                ctrl.mem_read     = 1'b1;
                ctrl.wb_sel       = wb_mem;
                ctrl.reg_we       = 1'b1;
            end
            op_store: begin
                imm               = imm_s;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.mem_write    = 1'b1;
            end
            op_jal: begin
                imm               = imm_j;
                ctrl.alu_src1_pc  = 1'b1;
                ctrl.alu_src2_imm = 1'b1;
                ctrl.wb_sel       = wb_pc_plus4;
                ctrl.reg_we       = 1'b1;
                ctrl.is_jal       = 1'b1;
            end
            op_jalr: begin
                ctrl.alu_src2_imm = 1'b1;
                ctrl.wb_sel       = wb_pc_plus4;
                ctrl.reg_we       = 1'b1;
                ctrl.is_jalr      = 1'b1;
            end
            op_br: begin
                imm               = imm_b;
                ctrl.alu_src1_pc  = 1'b1; // alu forms the target
                ctrl.alu_src2_imm = 1'b1;
                ctrl.cmp_op       = cmp_op_e'(funct3);
                ctrl.is_branch    = 1'b1;
            end
            default: begin
                ctrl = '0; // passes down as a bubble that only retires
            end
        endcase
    end

    always_comb begin
        id_ex_d.valid = i_if_id.valid;
        id_ex_d.pc    = i_if_id.pc;
        id_ex_d.ctrl  = ctrl;
        id_ex_d.rs1_v = i_rs1_v;
        id_ex_d.rs2_v = i_rs2_v;
        id_ex_d.imm   = imm;
        id_ex_d.rd    = inst[11:7];
    end

    assign o_decode_ready = !id_ex_q.valid || i_ex_accept;
    assign o_id_ex        = id_ex_q;

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            id_ex_q.valid <= 1'b0;
        end else if (o_decode_ready) begin
            id_ex_q <= id_ex_d;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (o_decode_ready && !i_flush && !i_if_id.valid) |=> !id_ex_q.valid)
        else $error("id_ex turned valid from an empty if_id");

endmodule

/* rtl/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import rv32i_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  id_ex_t      i_id_ex,
    output logic        o_accept,
    output logic        o_redirect,
    output logic [31:0] o_redirect_pc,
    output logic        o_req_valid,
    output mem_req_t    o_req,
    input  logic        i_resp_valid,
    input  logic [31:0] i_resp_data,
    output logic        o_retire_valid,
    output retire_t     o_retire
);

    typedef enum logic {st_idle, st_mem_wait} state_e;

    state_e      state_q;
    logic        resp_seen_q;
    logic [31:0] rdata_q;
    ctrl_t       ctrl;
    logic        is_mem;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] cmp_b;
    logic [31:0] alu_res;
    logic        cmp_res;
    logic        taken;
    logic [31:0] wb_value;

    assign ctrl   = i_id_ex.ctrl;
    assign is_mem = ctrl.mem_read || ctrl.mem_write;
    assign op_a   = ctrl.alu_src1_pc ? i_id_ex.pc : i_id_ex.rs1_v;
    assign op_b   = ctrl.alu_src2_imm ? i_id_ex.imm : i_id_ex.rs2_v;
    assign cmp_b  = ctrl.cmp_src_imm ? i_id_ex.imm : i_id_ex.rs2_v;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub: alu_res = op_a - op_b;
            alu_sll: alu_res = op_a << op_b[4:0];
            alu_xor: alu_res = op_a ^ op_b;
            alu_srl: alu_res = op_a >> op_b[4:0];
            alu_sra: alu_res = $signed(op_a) >>> op_b[4:0];
            alu_or:  alu_res = op_a | op_b;
            alu_and: alu_res = op_a & op_b;
            default: alu_res = op_a + op_b;
        endcase
        case (ctrl.cmp_op)
            cmp_beq:  cmp_res = (i_id_ex.rs1_v == cmp_b);
            cmp_bne:  cmp_res = (i_id_ex.rs1_v != cmp_b);
            cmp_blt:  cmp_res = ($signed(i_id_ex.rs1_v) < $signed(cmp_b));
            cmp_bge:  cmp_res = ($signed(i_id_ex.rs1_v) >= $signed(cmp_b));
            cmp_bltu: cmp_res = (i_id_ex.rs1_v < cmp_b);
            cmp_bgeu: cmp_res = (i_id_ex.rs1_v >= cmp_b);
            default:  cmp_res = 1'b0;
        endcase
        case (ctrl.wb_sel)
            wb_cmp:      wb_value = {31'h0, cmp_res};
            wb_u_imm:    wb_value = i_id_ex.imm;
            wb_pc_plus4: wb_value = i_id_ex.pc + 32'd4;
            wb_mem:      wb_value = rdata_q;
            default:     wb_value = alu_res;
        endcase
    end

    assign taken          = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && cmp_res);
    assign o_retire_valid = i_id_ex.valid &&
                            (state_q == st_idle ? !is_mem : resp_seen_q);
    assign o_accept       = o_retire_valid;
    assign o_redirect     = o_retire_valid && taken;
    assign o_redirect_pc  = {alu_res[31:1], 1'b0}; // bit 0 cleared for jalr
    assign o_req_valid    = i_id_ex.valid && is_mem && !resp_seen_q; // held until answered
    assign o_req          = '{addr: alu_res, wdata: i_id_ex.rs2_v, we: ctrl.mem_write};

    assign o_retire.pc       = i_id_ex.pc;
    assign o_retire.rd       = i_id_ex.rd;
    assign o_retire.rd_value = wb_value;
    assign o_retire.reg_we   = o_retire_valid && ctrl.reg_we && (i_id_ex.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (i_resp_valid) begin
            rdata_q <= i_resp_data;
        end
        if (rst) begin
            state_q     <= st_idle;
            resp_seen_q <= 1'b0;
        end else if (state_q == st_idle) begin
            if (o_req_valid) begin
                state_q <= st_mem_wait;
            end
        end else if (resp_seen_q) begin
            state_q     <= st_idle; // retired this cycle
            resp_seen_q <= 1'b0;
        end else if (i_resp_valid) begin
            resp_seen_q <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (o_retire_valid && is_mem) |-> $past(i_resp_valid))
        else $error("memory op retired without a response in the cycle before");

endmodule

/* rtl/fetch_stage.sv */
`timescale 1ns/100ps

module fetch_stage import rv32i_pkg::*; #(
    parameter logic [31:0] RESET_PC = 32'h0
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_decode_ready,
    input  logic        i_redirect,
    input  logic [31:0] i_redirect_pc,
    output logic        o_req_valid,
    output mem_req_t    o_req,
    input  logic        i_resp_valid,
    input  logic [31:0] i_resp_data,
    output if_id_t      o_if_id
);

    logic [31:0] pc_q;
    logic        pending_q; // read raised and not answered yet
    logic        stale_q;   // the read in flight belongs to the old path
    if_id_t      if_id_q;
    logic        can_refill;
    logic        resp_take;

    assign can_refill  = !if_id_q.valid || i_decode_ready || i_redirect;
    assign resp_take   = i_resp_valid && !stale_q && !i_redirect;
    assign o_req_valid = pending_q && !stale_q; // held until the arbiter takes it
    assign o_req       = '{addr: pc_q, wdata: 32'h0, we: 1'b0};
    assign o_if_id     = if_id_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q          <= RESET_PC;
            pending_q     <= 1'b0;
            stale_q       <= 1'b0;
            if_id_q.valid <= 1'b0;
        end else begin
            if (i_resp_valid && !stale_q) begin
                pending_q <= 1'b0;
            end else if (!pending_q && can_refill) begin
                pending_q <= 1'b1;
            end
            if (i_resp_valid) begin
                stale_q <= 1'b0; // a stale answer keeps pending set, so the target is asked next
            end else if (i_redirect && pending_q) begin
                stale_q <= 1'b1;
            end
            if (i_redirect) begin
                pc_q          <= i_redirect_pc;
                if_id_q.valid <= 1'b0;
            end else if (resp_take) begin
                pc_q    <= pc_q + 32'd4;
                if_id_q <= '{valid: 1'b1, pc: pc_q, inst: i_resp_data};
            end else if (i_decode_ready) begin
                if_id_q.valid <= 1'b0;
            end
        end
    end

endmodule

/* rtl/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter import rv32i_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_fetch_valid,
    input  mem_req_t i_fetch_req,
    input  logic     i_data_valid,
    input  mem_req_t i_data_req,
    output logic     o_fetch_grant,
    output logic     o_data_grant,
    output logic     o_fetch_resp,
    output logic     o_data_resp,
    output logic     o_mem_req_valid,
    output mem_req_t o_mem_req,
    input  logic     i_mem_rvalid
);

    typedef enum logic [1:0] {own_idle, own_fetch, own_data} owner_e;

    owner_e owner_q;

    assign o_data_grant    = (owner_q == own_idle) && i_data_valid;
    assign o_fetch_grant   = (owner_q == own_idle) && i_fetch_valid && !i_data_valid;
    assign o_mem_req_valid = o_data_grant || o_fetch_grant;
    assign o_mem_req       = i_data_valid ? i_data_req : i_fetch_req;
    assign o_fetch_resp    = i_mem_rvalid && (owner_q == own_fetch);
    assign o_data_resp     = i_mem_rvalid && (owner_q == own_data);

    always_ff @(posedge clk) begin
        if (rst || i_mem_rvalid) begin
            owner_q <= own_idle; // the next grant can go out one cycle after a response
        end else if (o_data_grant) begin
            owner_q <= own_data;
        end else if (o_fetch_grant) begin
            owner_q <= own_fetch;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (owner_q != own_idle && !i_mem_rvalid) |=> !o_mem_req_valid)
        else $error("memory request issued while another is outstanding");

endmodule

/* rtl/regfile.sv */
`timescale 1ns/100ps

module regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_we,
    input  logic [4:0]  i_rd_s,
    input  logic [31:0] i_rd_v,
    input  logic [4:0]  i_rs1_s,
    input  logic [4:0]  i_rs2_s,
    output logic [31:0] o_rs1_v,
    output logic [31:0] o_rs2_v
);

    logic [31:0] regs [1:31]; // x0 has no storage

    function automatic logic [31:0] read_reg(input logic [4:0] sel);
        if (sel == 5'd0) begin
            return 32'h0;
        end
        if (i_we && sel == i_rd_s) begin
            return i_rd_v; // same cycle write wins
        end
        return regs[sel];
    endfunction

    always_comb begin
        o_rs1_v = read_reg(i_rs1_s);
        o_rs2_v = read_reg(i_rs2_s);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (i_we && i_rd_s != 5'd0) begin
            regs[i_rd_s] <= i_rd_v;
        end
    end

    // execute masks reg_we for rd zero before it reaches this port
    assert property (@(posedge clk) disable iff (rst) i_we |-> (i_rd_s != 5'd0))
        else $error("register write enabled for x0");

endmodule

/* rtl/rv32i_pkg.sv */
package rv32i_pkg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011
    } opcode_e;

    // low three bits are funct3, the top bit is funct7[5]
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_op_e;

    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic [2:0] {
        wb_alu,
        wb_cmp,
        wb_u_imm,
        wb_pc_plus4,
        wb_mem
    } wb_sel_e;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       alu_src1_pc;  // pc instead of rs1
        logic       alu_src2_imm; // immediate instead of rs2
        cmp_op_e    cmp_op;
        logic       cmp_src_imm;
        wb_sel_e    wb_sel;
        logic       reg_we;
        logic       mem_read;
        logic       mem_write;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } if_id_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        ctrl_t       ctrl;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] imm;
        logic [4:0]  rd;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] rd_value;
        logic        reg_we;
    } retire_t;

endpackage

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/100ps --top-module tb_top \
    -f list.f -o sim_core

output="$(./obj_dir/sim_core)"
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "all tests passed"; then
    exit 0
fi
exit 1

/* test/core_checker.sv */
`timescale 1ns/100ps

module core_checker import rv32i_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    i_retire_valid,
    input  retire_t i_retire,
    output int      o_errors,
    output int      o_tests_passed,
    output int      o_tests_failed,
    output int      o_cur_test,
    output logic    o_done
);

    localparam int MAX_EXP = 64;

    typedef struct packed {
        logic [7:0]  test;
        logic [31:0] pc;
        logic [4:0]  rd; // zero means the retire writes no register
        logic [31:0] value;
    } expect_t;

    expect_t expected [0:MAX_EXP-1];
    int      n_exp;
    int      idx;
    int      test_errors;

    assign o_cur_test = (idx < n_exp) ? int'(expected[idx].test) : 0;
    assign o_done     = (n_exp > 0) && (idx >= n_exp);

    task automatic add_expected(input int test, input logic [31:0] pc, input logic [4:0] rd,
                                input logic [31:0] value);
        if (n_exp < MAX_EXP) begin
            expected[n_exp] = '{test: test[7:0], pc: pc, rd: rd, value: value};
            n_exp++;
        end
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("mismatch %s at pc %08h: got %08h, expected %08h",
                 name, i_retire.pc, got, want);
        test_errors++;
        o_errors++;
    endtask

    task automatic close_test(input int test);
        if (test_errors == 0) begin
            $display("test %0d passed", test);
            o_tests_passed++;
        end else begin
            $display("test %0d failed with %0d mismatches", test, test_errors);
            o_tests_failed++;
        end
        test_errors = 0;
    endtask

    // retire outputs are settled mid-cycle
    always @(negedge clk) begin
        expect_t exp_rec;
        logic    exp_we;
        if (rst) begin
            idx            = 0;
            test_errors    = 0;
            o_errors       = 0;
            o_tests_passed = 0;
            o_tests_failed = 0;
        end else if (i_retire_valid && idx < n_exp) begin
            exp_rec = expected[idx];
            exp_we  = (exp_rec.rd != 5'd0);
            if (i_retire.pc !== exp_rec.pc) begin
                report_mismatch("o_retire.pc", i_retire.pc, exp_rec.pc);
            end
            if (i_retire.reg_we !== exp_we) begin
                report_mismatch("o_retire.reg_we", {31'h0, i_retire.reg_we}, {31'h0, exp_we});
            end else if (exp_we) begin
                if (i_retire.rd !== exp_rec.rd) begin
                    report_mismatch("o_retire.rd", {27'h0, i_retire.rd}, {27'h0, exp_rec.rd});
                end
                if (i_retire.rd_value !== exp_rec.value) begin
                    report_mismatch("o_retire.rd_value", i_retire.rd_value, exp_rec.value);
                end
            end
            idx++;
            if (idx == n_exp || expected[idx].test != exp_rec.test) begin
                close_test(int'(exp_rec.test)); // last record of this test
            end
        end
    end

endmodule

/* test/core_patterns.txt */
// p byte_address instruction_word
// e test pc rd value, where rd 00 marks a retire without a register write
p 00000000 ff900093
p 00000004 00300113
p 00000008 402081b3
p 0000000c 00208233
p 00000010 4020d2b3
p 00000014 0020d333
p 00000018 0020a3b3
p 0000001c 0020b433
p 00000020 4010d493
p 00000024 123455b7
p 00000028 00001617
p 0000002c 67858693
p 00000030 00c6c733
p 00000034 002767b3
p 00000038 10d02023
p 0000003c 10002803
p 00000040 00180893
p 00000044 00208463
p 00000048 00209463
p 0000004c 00100913
p 00000050 0020c463
p 00000054 00200913
p 00000058 0020e463
p 0000005c 0020d463
p 00000060 0020f463
p 00000064 00300913
p 00000068 00c009ef
p 0000006c 00400913
p 00000070 00500913
p 00000074 01098a67
p 00000078 00600913
p 0000007c 00500013
p 00000080 00200ab3
p 00000084 0000006f
e 1 00000000 01 fffffff9
e 1 00000004 02 00000003
e 1 00000008 03 fffffff6
e 1 0000000c 04 fffffffc
e 1 00000010 05 ffffffff
e 1 00000014 06 1fffffff
e 1 00000018 07 00000001
e 1 0000001c 08 00000000
e 1 00000020 09 fffffffc
e 2 00000024 0b 12345000
e 2 00000028 0c 00001028
e 3 0000002c 0d 12345678
e 3 00000030 0e 12344650
e 3 00000034 0f 12344653
e 4 00000038 00 00000000
e 4 0000003c 10 12345678
e 4 00000040 11 12345679
e 5 00000044 00 00000000
e 5 00000048 00 00000000
e 5 00000050 00 00000000
e 5 00000058 00 00000000
e 5 0000005c 00 00000000
e 5 00000060 00 00000000
e 5 00000068 13 0000006c
e 5 00000074 14 00000078
e 6 0000007c 00 00000000
e 6 00000080 15 00000003

/* test/tb_top.sv */
`timescale 1ns/100ps

module tb_top import rv32i_pkg::*; ();

    localparam int MEM_WORDS    = 1024;
    localparam int TEST_TIMEOUT = 1000; // cycles allowed for each test

    logic        clk;
    logic        rst;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_rvalid;
    logic [31:0] mem_rdata;
    logic        retire_valid;
    retire_t     retire;
    logic [31:0] mem [0:MEM_WORDS-1];
    mem_req_t    held_req;
    logic        busy;
    int          countdown;
    logic        mem_fault;
    logic        timed_out;
    int          last_test;
    int          chk_errors;
    int          chk_passed;
    int          chk_failed;
    int          chk_cur_test;
    logic        chk_done;

    core_top dut0 (
        .clk(clk), .rst(rst),
        .o_mem_req_valid(mem_req_valid), .o_mem_req(mem_req),
        .i_mem_rvalid(mem_rvalid), .i_mem_rdata(mem_rdata),
        .o_retire_valid(retire_valid), .o_retire(retire)
    );

    core_checker retire_chk (
        .clk(clk), .rst(rst), .i_retire_valid(retire_valid), .i_retire(retire),
        .o_errors(chk_errors), .o_tests_passed(chk_passed), .o_tests_failed(chk_failed),
        .o_cur_test(chk_cur_test), .o_done(chk_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // memory model answers one request 1 to 4 cycles after it was raised
    initial begin
        void'($urandom(32'h084b5374));
        busy       = 1'b0;
        countdown  = 0;
        mem_fault  = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = 32'h0;
        forever begin
            @(negedge clk);
            if (!rst && mem_req_valid) begin
                if (busy || mem_req.addr[31:12] != 20'h0) begin
                    $display("memory model got a request at %08h while busy or out of range",
                             mem_req.addr);
                    mem_fault = 1'b1;
                end
                held_req  = mem_req;
                busy      = 1'b1;
                countdown = $urandom % 4 + 1;
            end
            @(posedge clk);
            #1;
            mem_rvalid = 1'b0;
            if (busy) begin
                countdown--;
                if (countdown == 0) begin
                    mem_rvalid = 1'b1;
                    mem_rdata  = mem[held_req.addr[11:2]];
                    if (held_req.we) begin
                        mem[held_req.addr[11:2]] = held_req.wdata;
                    end
                    busy = 1'b0;
                end
            end
        end
    end

    task automatic load_patterns();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hbad00000 | (i << 2);
        end
        fd = $fopen("test/core_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open test/core_patterns.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) == "p") begin
                if ($sscanf(line.substr(2, line.len() - 1), "%h %h", f0, f1) == 2) begin
                    mem[f0[11:2]] = f1;
                end
            end else if (n > 1 && line.getc(0) == "e") begin
                n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h", f0, f1, f2, f3);
                if (n == 4) begin
                    retire_chk.add_expected(int'(f0), f1, f2[4:0], f3);
                    if (int'(f0) > last_test) begin
                        last_test = int'(f0);
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_for_test(input int test);
        int cycles;
        cycles = 0;
        while (!chk_done && chk_cur_test <= test && cycles < TEST_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!chk_done && chk_cur_test <= test) begin
            $display("timeout: test %0d stalled, its records did not retire within %0d cycles",
                     test, TEST_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        rst       = 1'b1;
        timed_out = 1'b0;
        load_patterns();
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int t = 1; t <= last_test && !timed_out; t++) begin
            wait_for_test(t);
        end
        $display("summary: %0d clean, %0d with mismatches, %0d mismatches in all, fault %s",
                 chk_passed, chk_failed, chk_errors, mem_fault ? "yes" : "no");
        if (!timed_out && !mem_fault && chk_done && chk_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule
